// ==== sim/cache_patterns.txt ====
# fields are name, op, address or select, wdata, wstrb, expected and hold
# R reads, W writes and S reads a statistics counter
# hold 1 stalls aw_ready before the write
rd_miss_first   R 00001000 00000000 0 a5a50400 0
rd_hit_other    R 00001004 00000000 0 a5a50401 0
wr_hit_merge    W 00001000 11223344 3 a5a53344 0
rd_hit_merged   R 00001000 00000000 0 a5a53344 0
wr_miss_noalloc W 00002008 cafef00d c cafe0802 0
rd_miss_written R 00002008 00000000 0 cafe0802 0
stat_hits       S 00000000 00000000 0 00000003 0
stat_rd_misses  S 00000001 00000000 0 00000002 0
stat_wr_misses  S 00000002 00000000 0 00000001 0
stat_invalidate S 0000000f 00000000 0 deadbeef 0
rd_after_inval  R 00001004 00000000 0 a5a50401 0
stat_rd_inval   S 00000001 00000000 0 00000003 0
bp_00           W 00003000 5a5a0000 f 5a5a0000 1
bp_01           W 00003004 5a5a0001 f 5a5a0001 0
bp_02           W 00003008 5a5a0002 f 5a5a0002 0
bp_03           W 0000300c 5a5a0003 f 5a5a0003 0
bp_04           W 00003010 5a5a0004 f 5a5a0004 0
bp_05           W 00003014 5a5a0005 f 5a5a0005 0
bp_06           W 00003018 5a5a0006 f 5a5a0006 0
bp_07           W 0000301c 5a5a0007 f 5a5a0007 0
bp_08           W 00003020 5a5a0008 f 5a5a0008 0
bp_09           W 00003024 5a5a0009 f 5a5a0009 0
bp_10           W 00003028 5a5a000a f 5a5a000a 0
bp_11           W 0000302c 5a5a000b f 5a5a000b 0
bp_12           W 00003030 5a5a000c f 5a5a000c 0
bp_13           W 00003034 5a5a000d f 5a5a000d 0
bp_14           W 00003038 5a5a000e f 5a5a000e 0
bp_15           W 0000303c 5a5a000f f 5a5a000f 0
bp_last         W 00003000 77777777 f 77777777 0
rd_bp_last      R 00003000 00000000 0 77777777 0
stat_wr_final   S 00000002 00000000 0 00000012 0

// ==== memory_cache.f ====
+incdir+source
source/cache_pkg.sv
source/axi_pkg.sv
source/cache_fsm.sv
source/tag_store.sv
source/data_store.sv
source/line_fill.sv
source/write_buffer.sv
source/stats_counters.sv
source/memory_cache_top.sv
sim/memory_cache_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = memory_cache_tb
FILELIST  = memory_cache.f
OBJ_DIR   = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/memory_cache_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module memory_cache_tb;

   import cache_pkg::*;
   import axi_pkg::*;

   localparam int name_w      = 8*24;
   localparam int wait_limit  = 200;   // cycles per wait
   localparam int hold_cycles = 100;   // aw_ready stall for back-pressure
   localparam int line_words  = 2;

   logic        clk;
   logic        ctrl_reset;
   cpu_req_t    cpu_req;
   cpu_rsp_t    cpu_rsp;
   stat_req_t   stat_req;
   stat_rsp_t   stat_rsp;
   axi_rd_req_t rd_req;
   axi_rd_rsp_t rd_rsp;
   axi_wr_req_t wr_req;
   axi_wr_rsp_t wr_rsp;
   logic        wb_empty;

   // memory model
   logic [31:0]       mem_words [int unsigned];
   logic [31:0]       pend_data [int unsigned];   // memory words due after the next drain
   logic [name_w-1:0] pend_name [int unsigned];
   integer            seed;
   logic [31:0]       rnd;
   int unsigned       cycle;
   int unsigned       hold_until;
   int unsigned       rd_base;
   int unsigned       rd_beat;
   logic              rd_active;
   int unsigned       ar_word;
   int unsigned       aw_word;
   int unsigned       aw_word_q;
   logic [3:0]        w_strb_q;
   logic [31:0]       w_data_q;
   logic              ar_hs;
   logic              r_hs;
   logic              aw_hs;
   logic              w_hs;

   // pattern playback
   int                errors;
   int                timeouts;
   int                n_patterns;
   logic              timed_out;
   int                fd;
   int                n_fields;
   logic [8*128-1:0]  line_buf;
   logic [name_w-1:0] pat_name;
   logic [7:0]        pat_op;
   logic [31:0]       pat_addr;
   logic [31:0]       pat_wdata;
   logic [3:0]        pat_wstrb;
   logic [31:0]       pat_exp;
   int                pat_hold;
   logic [31:0]       act;

   memory_cache_top dut0
   (
      .clk        (clk),
      .ctrl_reset (ctrl_reset),
      .cpu_req    (cpu_req),
      .cpu_rsp    (cpu_rsp),
      .stat_req   (stat_req),
      .stat_rsp   (stat_rsp),
      .rd_req     (rd_req),
      .rd_rsp     (rd_rsp),
      .wr_req     (wr_req),
      .wr_rsp     (wr_rsp),
      .wb_empty   (wb_empty)
   );

   always #5 clk = ~clk;

   // untouched words hold their word address xor a5a50000
   function automatic logic [31:0] read_word(input int unsigned w);
      if (mem_words.exists(w))
         return mem_words[w];
      return w ^ 32'hA5A50000;
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] strb);
      logic [31:0] res;
      res = old;
      for (int b = 0; b < 4; b++)
      begin
         if (strb[b])
            res[b*8 +: 8] = data[b*8 +: 8];
      end
      return res;
   endfunction

   ////////////////////////////////////////////////////////////
   // AXI memory model
   ////////////////////////////////////////////////////////////
   initial
   begin
      seed       = 84;
      cycle      = 0;
      hold_until = 0;
      rd_active  = 1'b0;
      rd_beat    = 0;
      rd_base    = 0;
      aw_word    = 0;
      rd_rsp     = '{ar_ready: 1'b1, r_valid: 1'b0, r_data: '0, r_last: 1'b0};
      wr_rsp     = '{aw_ready: 1'b1, w_ready: 1'b1};
      forever
      begin
         @(negedge clk);   // handshakes seen mid-cycle and taken at the next edge
         ar_hs     = rd_req.ar_valid && rd_rsp.ar_ready;
         r_hs      = rd_req.r_ready && rd_rsp.r_valid;
         aw_hs     = wr_req.aw_valid && wr_rsp.aw_ready;
         w_hs      = wr_req.w_valid && wr_rsp.w_ready;
         ar_word   = {2'b00, rd_req.ar_addr[31:2]};
         aw_word_q = {2'b00, wr_req.aw_addr[31:2]};
         w_strb_q  = wr_req.w_strb;
         w_data_q  = wr_req.w_data;
         @(posedge clk);
         #1;
         cycle = cycle + 1;
         rnd   = $random(seed);
         if (ar_hs)
         begin
            rd_base   = ar_word;
            rd_beat   = 0;
            rd_active = 1'b1;
         end
         else if (r_hs)
         begin
            if (rd_beat == line_words - 1)
               rd_active = 1'b0;   // last beat taken
            rd_beat = rd_beat + 1;
         end
         if (aw_hs)
            aw_word = aw_word_q;
         if (w_hs)
            mem_words[aw_word] = merge_bytes(read_word(aw_word), w_data_q, w_strb_q);
         // ready and valid may drop for a cycle after each handshake
         rd_rsp.ar_ready = !(ar_hs && rnd[0]);
         rd_rsp.r_valid  = rd_active && !(r_hs && rnd[1]);
         rd_rsp.r_data   = read_word(rd_base + rd_beat);
         rd_rsp.r_last   = (rd_beat == line_words - 1);
         wr_rsp.aw_ready = !(aw_hs && rnd[2]) && (cycle >= hold_until);
         wr_rsp.w_ready  = !(w_hs && rnd[3]);
      end
   end

   ////////////////////////////////////////////////////////////
   // request tasks
   ////////////////////////////////////////////////////////////
   task automatic cpu_access(input logic [name_w-1:0] name, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] wstrb,
                             output logic [31:0] rdata);
      int   i;
      logic got;
      got   = 1'b0;
      rdata = '0;
      @(posedge clk);
      #1;
      cpu_req.req      = 1'b1;
      cpu_req.addr.raw = addr[29:0];
      cpu_req.wdata    = wdata;
      cpu_req.wstrb    = wstrb;
      for (i = 0; i < wait_limit && !got; i++)
      begin
         @(negedge clk);
         if (cpu_rsp.ack)
         begin
            got   = 1'b1;
            rdata = cpu_rsp.rdata;
         end
      end
      if (!got)
      begin
         $display("timeout: %0s got no cpu ack within %0d cycles", name, wait_limit);
         timeouts  = timeouts + 1;
         timed_out = 1'b1;
      end
      @(posedge clk);
      #1;
      cpu_req.req = 1'b0;
   endtask

   task automatic stat_access(input logic [name_w-1:0] name, input logic [3:0] sel,
                              output logic [31:0] data);
      int   i;
      logic got;
      got  = 1'b0;
      data = '0;
      @(posedge clk);
      #1;
      stat_req.req = 1'b1;
      stat_req.sel = sel;
      @(posedge clk);
      #1;
      stat_req.req = 1'b0;   // one-cycle request
      for (i = 0; i < wait_limit && !got; i++)
      begin
         @(negedge clk);
         if (stat_rsp.ack)
         begin
            got  = 1'b1;
            data = stat_rsp.data;
         end
      end
      if (!got)
      begin
         $display("timeout: %0s got no statistics ack within %0d cycles", name, wait_limit);
         timeouts  = timeouts + 1;
         timed_out = 1'b1;
      end
   endtask

   // wait for the write buffer to empty before comparing memory
   task automatic drain_writes(input logic [name_w-1:0] name);
      int          i;
      logic        got;
      logic [31:0] mem_act;
      got = 1'b0;
      for (i = 0; i < wait_limit && !got; i++)
      begin
         @(negedge clk);
         got = wb_empty;
      end
      if (!got)
      begin
         $display("timeout: write buffer did not drain within %0d cycles before %0s",
                  wait_limit, name);
         timeouts  = timeouts + 1;
         timed_out = 1'b1;
      end
      else
      begin
         foreach (pend_data[w])
         begin
            mem_act = read_word(w);
            if (mem_act !== pend_data[w])
            begin
               $display("FAIL %0s: expected %h, actual %h in memory word %h",
                        pend_name[w], pend_data[w], mem_act, w);
               errors = errors + 1;
            end
         end
      end
      pend_data.delete();
      pend_name.delete();
   endtask

   ////////////////////////////////////////////////////////////
   // pattern playback
   ////////////////////////////////////////////////////////////
   initial
   begin
      clk        = 1'b0;
      ctrl_reset = 1'b1;
      cpu_req    = '0;
      stat_req   = '0;
      errors     = 0;
      timeouts   = 0;
      n_patterns = 0;
      timed_out  = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      ctrl_reset = 1'b0;

      fd = $fopen("sim/cache_patterns.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the pattern file sim/cache_patterns.txt");
         errors = errors + 1;
      end
      else
      begin
         while (!timed_out && $fscanf(fd, "%s", pat_name) == 1)
         begin
            if (pat_name == "#")
               n_fields = $fgets(line_buf, fd);   // skip comment line
            else
            begin
               n_fields = $fscanf(fd, "%s %h %h %h %h %d", pat_op, pat_addr, pat_wdata,
                                  pat_wstrb, pat_exp, pat_hold);
               n_patterns = n_patterns + 1;
               if (n_fields != 6)
               begin
                  $display("pattern %0s is missing fields", pat_name);
                  errors = errors + 1;
               end
               else
                  case (pat_op)
                     "R":
                     begin
                        drain_writes(pat_name);   // memory must be current for a fill
                        if (!timed_out)
                           cpu_access(pat_name, pat_addr, 32'h0, 4'h0, act);
                        if (!timed_out && act !== pat_exp)
                        begin
                           $display("FAIL %0s: expected %h, actual %h", pat_name, pat_exp, act);
                           errors = errors + 1;
                        end
                     end
                     "W":
                     begin
                        if (pat_hold != 0)
                           hold_until = cycle + hold_cycles;
                        cpu_access(pat_name, pat_addr, pat_wdata, pat_wstrb, act);
                        pend_data[{2'b00, pat_addr[31:2]}] = pat_exp;   // last write wins
                        pend_name[{2'b00, pat_addr[31:2]}] = pat_name;
                     end
                     "S":
                     begin
                        drain_writes(pat_name);
                        if (!timed_out)
                           stat_access(pat_name, pat_addr[3:0], act);
                        if (!timed_out && act !== pat_exp)
                        begin
                           $display("FAIL %0s: expected %h, actual %h", pat_name, pat_exp, act);
                           errors = errors + 1;
                        end
                     end
                     default:
                     begin
                        $display("pattern %0s has an unknown op code %0s", pat_name, pat_op);
                        errors = errors + 1;
                     end
                  endcase
            end
         end
         $fclose(fd);
         if (!timed_out)
            drain_writes("end of patterns");
         if (n_patterns == 0)
         begin
            $display("the pattern file holds no patterns");
            errors = errors + 1;
         end
      end

      $display("closing: %0d patterns, %0d mismatches, %0d timeouts",
               n_patterns, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== source/memory_cache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_macros.svh"

module memory_cache_top
(
   input  logic                 clk,
   input  logic                 ctrl_reset,
   input  cache_pkg::cpu_req_t  cpu_req,
   output cache_pkg::cpu_rsp_t  cpu_rsp,
   input  cache_pkg::stat_req_t stat_req,
   output cache_pkg::stat_rsp_t stat_rsp,
   output axi_pkg::axi_rd_req_t rd_req,
   input  axi_pkg::axi_rd_rsp_t rd_rsp,
   output axi_pkg::axi_wr_req_t wr_req,
   input  axi_pkg::axi_wr_rsp_t wr_rsp,
   output logic                 wb_empty
);

   import cache_pkg::*;

   stat_event_t              events;
   logic                     hit;
   logic                     ack;
   logic                     fill_start;
   logic                     fill_done;
   logic                     fill_wr;
   logic [`CACHE_WSEL_W-1:0] fill_wsel;
   logic [`CACHE_DATA_W-1:0] fill_data;
   logic                     data_wr_en;
   logic                     wb_push;
   logic                     wb_full;
   logic                     invalidate;
   logic [`CACHE_DATA_W-1:0] rdata;

   assign cpu_rsp = '{ack: ack, rdata: rdata};

   cache_fsm fsm0
   (
      .clk        (clk),
      .ctrl_reset (ctrl_reset),
      .cpu_req    (cpu_req),
      .hit        (hit),
      .fill_done  (fill_done),
      .wb_full    (wb_full),
      .ack        (ack),
      .fill_start (fill_start),
      .data_wr_en (data_wr_en),
      .wb_push    (wb_push),
      .events     (events)
   );

   // tag and valid land with the last beat
   tag_store tags0
   (
      .clk        (clk),
      .ctrl_reset (ctrl_reset),
      .addr       (cpu_req.addr),
      .fill_wr    (fill_done),
      .invalidate (invalidate),
      .hit        (hit)
   );

   data_store data0
   (
      .clk        (clk),
      .addr       (cpu_req.addr),
      .wdata      (cpu_req.wdata),
      .wstrb      (cpu_req.wstrb),
      .data_wr_en (data_wr_en),
      .fill_wr    (fill_wr),
      .fill_wsel  (fill_wsel),
      .fill_data  (fill_data),
      .rdata      (rdata)
   );

   line_fill fill0
   (
      .clk        (clk),
      .ctrl_reset (ctrl_reset),
      .addr       (cpu_req.addr),
      .fill_start (fill_start),
      .rd_req     (rd_req),
      .rd_rsp     (rd_rsp),
      .fill_wr    (fill_wr),
      .fill_wsel  (fill_wsel),
      .fill_data  (fill_data),
      .fill_done  (fill_done)
   );

   write_buffer wbuf0
   (
      .clk        (clk),
      .ctrl_reset (ctrl_reset),
      .push       (wb_push),
      .addr       (cpu_req.addr),
      .wdata      (cpu_req.wdata),
      .wstrb      (cpu_req.wstrb),
      .full       (wb_full),
      .empty      (wb_empty),
      .wr_req     (wr_req),
      .wr_rsp     (wr_rsp)
   );

   stats_counters stats0
   (
      .clk        (clk),
      .ctrl_reset (ctrl_reset),
      .events     (events),
      .stat_req   (stat_req),
      .stat_rsp   (stat_rsp),
      .invalidate (invalidate)
   );

endmodule

`default_nettype wire

// ==== source/stats_counters.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_macros.svh"

module stats_counters
(
   input  logic                   clk,
   input  logic                   ctrl_reset,
   input  cache_pkg::stat_event_t events,
   input  cache_pkg::stat_req_t   stat_req,
   output cache_pkg::stat_rsp_t   stat_rsp,
   output logic                   invalidate
);

   logic [`CACHE_STAT_W-1:0] hit_cnt;
   logic [`CACHE_STAT_W-1:0] rd_miss_cnt;
   logic [`CACHE_STAT_W-1:0] wr_miss_cnt;
   logic [`CACHE_STAT_W-1:0] rd_data;
   logic                     rsp_ack;

   always_ff @(posedge clk or posedge ctrl_reset)
   begin
      if (ctrl_reset)
      begin
         hit_cnt     <= '0;
         rd_miss_cnt <= '0;
         wr_miss_cnt <= '0;
         rsp_ack     <= 1'b0;
         invalidate  <= 1'b0;
      end
      else
      begin
         if (events.hit)     hit_cnt     <= hit_cnt + 1'b1;
         if (events.rd_miss) rd_miss_cnt <= rd_miss_cnt + 1'b1;
         if (events.wr_miss) wr_miss_cnt <= wr_miss_cnt + 1'b1;
         rsp_ack    <= stat_req.req;   // answer one cycle later
         invalidate <= stat_req.req && (stat_req.sel == `CACHE_STAT_INVAL);
      end
   end

   // readout latched from the sel seen with req
   always_ff @(posedge clk)
   begin
      if (stat_req.req)
         case (stat_req.sel)
            `CACHE_STAT_HIT:     rd_data <= hit_cnt;
            `CACHE_STAT_RD_MISS: rd_data <= rd_miss_cnt;
            `CACHE_STAT_WR_MISS: rd_data <= wr_miss_cnt;
            `CACHE_STAT_INVAL:   rd_data <= `CACHE_INVAL_MARKER;
            default:             rd_data <= '0;   // unused codes
         endcase
   end

   assign stat_rsp = '{ack: rsp_ack, data: rd_data};

endmodule

`default_nettype wire

// ==== source/write_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_macros.svh"

module write_buffer
#(
   parameter int DEPTH_LOG2 = `CACHE_WB_DEPTH_LOG2
)
(
   input  logic                     clk,
   input  logic                     ctrl_reset,
   input  logic                     push,
   input  cache_pkg::cache_addr_u   addr,
   input  logic [`CACHE_DATA_W-1:0] wdata,
   input  logic [`CACHE_STRB_W-1:0] wstrb,
   output logic                     full,
   output logic                     empty,
   output axi_pkg::axi_wr_req_t     wr_req,
   input  axi_pkg::axi_wr_rsp_t     wr_rsp
);

   typedef struct packed
   {
      logic [`CACHE_STRB_W-1:0]   strb;
      logic [`CACHE_ADDR_W-3:0]   waddr;   // word address
      logic [`CACHE_DATA_W-1:0]   data;
   } wb_entry_t;

   typedef enum logic [1:0] {drain_idle, drain_addr, drain_data} drain_t;

   wb_entry_t           fifo_mem [2**DEPTH_LOG2];
   wb_entry_t           head;
   logic [DEPTH_LOG2:0] wr_ptr;
   logic [DEPTH_LOG2:0] rd_ptr;
   logic                pop;
   drain_t              drain;

   ////////////////////////////////////////////////////////////
   // FIFO
   ////////////////////////////////////////////////////////////
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                  (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);
   assign head  = fifo_mem[rd_ptr[DEPTH_LOG2-1:0]];
   assign pop   = (drain == drain_data) && wr_rsp.w_ready;   // entry leaves once written

   always_ff @(posedge clk)
   begin
      if (push)
         fifo_mem[wr_ptr[DEPTH_LOG2-1:0]] <= '{strb: wstrb, waddr: addr.raw[`CACHE_ADDR_W-1:2],
                                               data: wdata};
   end

   always_ff @(posedge clk or posedge ctrl_reset)
   begin
      if (ctrl_reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // drain engine
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or posedge ctrl_reset)
   begin
      if (ctrl_reset)
         drain <= drain_idle;
      else
         case (drain)
            drain_idle: if (!empty) drain <= drain_addr;
            drain_addr: if (wr_rsp.aw_ready) drain <= drain_data;
            drain_data: if (wr_rsp.w_ready) drain <= drain_idle;
            default:    drain <= drain_idle;
         endcase
   end

   assign wr_req = '{aw_addr:  {2'b00, head.waddr, 2'b00},
                     aw_valid: (drain == drain_addr),
                     w_valid:  (drain == drain_data),
                     w_strb:   head.strb,
                     w_data:   head.data};

   a_no_overflow: assert property (@(posedge clk) disable iff (ctrl_reset) push |-> !full);

endmodule

`default_nettype wire

// ==== source/line_fill.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_macros.svh"

module line_fill
(
   input  logic                     clk,
   input  logic                     ctrl_reset,
   input  cache_pkg::cache_addr_u   addr,
   input  logic                     fill_start,
   output axi_pkg::axi_rd_req_t     rd_req,
   input  axi_pkg::axi_rd_rsp_t     rd_rsp,
   output logic                     fill_wr,
   output logic [`CACHE_WSEL_W-1:0] fill_wsel,
   output logic [`CACHE_DATA_W-1:0] fill_data,
   output logic                     fill_done
);

   typedef enum logic [1:0] {rd_idle, rd_addr, rd_beats} rd_state_t;

   rd_state_t                state;
   logic [`CACHE_WSEL_W-1:0] beat;

   always_ff @(posedge clk or posedge ctrl_reset)
   begin
      if (ctrl_reset)
      begin
         state <= rd_idle;
         beat  <= '0;
      end
      else
      begin
         case (state)
            rd_idle:  if (fill_start) state <= rd_addr;
            rd_addr:  if (rd_rsp.ar_ready) state <= rd_beats;
            rd_beats: if (fill_done) state <= rd_idle;
            default:  state <= rd_idle;
         endcase
         if (fill_start)
            beat <= '0;
         else if (fill_wr)
            beat <= beat + 1'b1;   // lowest word arrives first
      end
   end

   // line-aligned burst address
   assign rd_req = '{ar_addr:  {2'b00, addr.raw[`CACHE_ADDR_W-1:`CACHE_WSEL_W+2],
                                {(`CACHE_WSEL_W+2){1'b0}}},
                     ar_valid: (state == rd_addr),
                     r_ready:  (state == rd_beats)};

   assign fill_wr   = (state == rd_beats) && rd_rsp.r_valid;   // beat accepted
   assign fill_wsel = beat;
   assign fill_data = rd_rsp.r_data;
   assign fill_done = fill_wr && rd_rsp.r_last;   // also writes tag and valid

   a_ar_hold: assert property (@(posedge clk) disable iff (ctrl_reset)
      rd_req.ar_valid && !rd_rsp.ar_ready |=> rd_req.ar_valid && $stable(rd_req.ar_addr));

endmodule

`default_nettype wire

// ==== source/data_store.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_macros.svh"

module data_store
(
   input  logic                     clk,
   input  cache_pkg::cache_addr_u   addr,
   input  logic [`CACHE_DATA_W-1:0] wdata,
   input  logic [`CACHE_STRB_W-1:0] wstrb,
   input  logic                     data_wr_en,
   input  logic                     fill_wr,
   input  logic [`CACHE_WSEL_W-1:0] fill_wsel,
   input  logic [`CACHE_DATA_W-1:0] fill_data,
   output logic [`CACHE_DATA_W-1:0] rdata
);

   // one bank per word of the line
   logic [`CACHE_DATA_W-1:0] mem [2**`CACHE_WSEL_W][2**`CACHE_INDEX_W];

   logic [`CACHE_WSEL_W-1:0] wr_sel;
   logic [`CACHE_STRB_W-1:0] wr_be;
   logic [`CACHE_DATA_W-1:0] wr_word;

   // fill writes the full word, a hit write only the strobed bytes
   assign wr_sel  = fill_wr ? fill_wsel : addr.fields.wsel;
   assign wr_be   = fill_wr ? '1 : (data_wr_en ? wstrb : '0);
   assign wr_word = fill_wr ? fill_data : wdata;

   always_ff @(posedge clk)
   begin
      for (int b = 0; b < `CACHE_STRB_W; b++)
      begin
         if (wr_be[b])
            mem[wr_sel][addr.fields.index][b*8 +: 8] <= wr_word[b*8 +: 8];
      end
      rdata <= mem[addr.fields.wsel][addr.fields.index];   // registered read word
   end

   a_one_writer: assert property (@(posedge clk) !(fill_wr && data_wr_en));

endmodule

`default_nettype wire

// ==== source/tag_store.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_macros.svh"

module tag_store
(
   input  logic                   clk,
   input  logic                   ctrl_reset,
   input  cache_pkg::cache_addr_u addr,
   input  logic                   fill_wr,
   input  logic                   invalidate,
   output logic                   hit
);

   logic [`CACHE_TAG_W-1:0]      tag_mem [2**`CACHE_INDEX_W];
   logic [2**`CACHE_INDEX_W-1:0] valid;
   logic [`CACHE_TAG_W-1:0]      tag_q;
   logic                         valid_q;

   always_ff @(posedge clk)
   begin
      if (fill_wr)
         tag_mem[addr.fields.index] <= addr.fields.tag;
      tag_q <= tag_mem[addr.fields.index];   // synchronous read
   end

   always_ff @(posedge clk or posedge ctrl_reset)
   begin
      if (ctrl_reset)
      begin
         valid   <= '0;
         valid_q <= 1'b0;
      end
      else
      begin
         if (invalidate)
            valid <= '0;   // flush whole cache
         else if (fill_wr)
            valid[addr.fields.index] <= 1'b1;
         valid_q <= valid[addr.fields.index];
      end
   end

   assign hit = valid_q && (tag_q == addr.fields.tag);

endmodule

`default_nettype wire

// ==== source/cache_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_fsm
(
   input  logic                   clk,
   input  logic                   ctrl_reset,
   input  cache_pkg::cpu_req_t    cpu_req,
   input  logic                   hit,
   input  logic                   fill_done,
   input  logic                   wb_full,
   output logic                   ack,
   output logic                   fill_start,
   output logic                   data_wr_en,
   output logic                   wb_push,
   output cache_pkg::stat_event_t events
);

   typedef enum logic [2:0] {idle, lookup, write_wait, fill, reread, respond, gap} state_t;

   state_t state;
   state_t state_nxt;
   logic   is_wr;

   assign is_wr = |cpu_req.wstrb;

   ////////////////////////////////////////////////////////////
   // sequencing
   ////////////////////////////////////////////////////////////
   always_comb
   begin
      state_nxt = state;
      case (state)
         idle:       if (cpu_req.req) state_nxt = lookup;
         lookup:
         begin
            if (is_wr)    state_nxt = write_wait;   // writes always go to the buffer
            else if (hit) state_nxt = respond;
            else          state_nxt = fill;
         end
         write_wait: if (!wb_full) state_nxt = gap;
         fill:       if (fill_done) state_nxt = reread;
         reread:     state_nxt = respond;   // stores see the new line here
         respond:    state_nxt = gap;
         gap:        state_nxt = idle;      // ack cycle
         default:    state_nxt = idle;
      endcase
   end

   always_ff @(posedge clk or posedge ctrl_reset)
   begin
      if (ctrl_reset)
         state <= idle;
      else
         state <= state_nxt;
   end

   assign ack        = (state == gap);
   assign fill_start = (state == lookup) && !is_wr && !hit;
   assign wb_push    = (state == write_wait) && !wb_full;
   assign data_wr_en = wb_push && hit;   // write hit also updates the line

   // classified once in lookup
   assign events = '{hit:     (state == lookup) && hit,
                     rd_miss: (state == lookup) && !is_wr && !hit,
                     wr_miss: (state == lookup) && is_wr && !hit};

   a_ack_pulse: assert property (@(posedge clk) disable iff (ctrl_reset)
      ack |=> !ack);

   // a line fill only ever serves a read
   a_no_fill_on_write: assert property (@(posedge clk) disable iff (ctrl_reset)
      (state == fill) |-> !is_wr);

endmodule

`default_nettype wire

// ==== source/axi_pkg.sv ====
`default_nettype none

`include "cache_macros.svh"

package axi_pkg;

   // read address and data channels
   typedef struct packed
   {
      logic [`CACHE_ADDR_W+1:0] ar_addr;
      logic                     ar_valid;
      logic                     r_ready;
   } axi_rd_req_t;

   typedef struct packed
   {
      logic                     ar_ready;
      logic                     r_valid;
      logic [`CACHE_DATA_W-1:0] r_data;
      logic                     r_last;
   } axi_rd_rsp_t;

   // write address and data channels, no response channel
   typedef struct packed
   {
      logic [`CACHE_ADDR_W+1:0] aw_addr;
      logic                     aw_valid;
      logic                     w_valid;
      logic [`CACHE_STRB_W-1:0] w_strb;
      logic [`CACHE_DATA_W-1:0] w_data;
   } axi_wr_req_t;

   typedef struct packed
   {
      logic aw_ready;
      logic w_ready;
   } axi_wr_rsp_t;

endpackage

`default_nettype wire

// ==== source/cache_pkg.sv ====
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

   // one address word, seen flat or split for lookup
   typedef union packed
   {
      logic [`CACHE_ADDR_W-1:0] raw;
      struct packed
      {
         logic [`CACHE_TAG_W-1:0]   tag;
         logic [`CACHE_INDEX_W-1:0] index;
         logic [`CACHE_WSEL_W-1:0]  wsel;
         logic [1:0]                byte_off;
      } fields;
   } cache_addr_u;

   typedef struct packed
   {
      logic                     req;
      cache_addr_u              addr;
      logic [`CACHE_DATA_W-1:0] wdata;
      logic [`CACHE_STRB_W-1:0] wstrb;   // nonzero means write
   } cpu_req_t;

   typedef struct packed
   {
      logic                     ack;
      logic [`CACHE_DATA_W-1:0] rdata;
   } cpu_rsp_t;

   typedef struct packed
   {
      logic                         req;
      logic [`CACHE_STAT_SEL_W-1:0] sel;
   } stat_req_t;

   typedef struct packed
   {
      logic                     ack;
      logic [`CACHE_STAT_W-1:0] data;
   } stat_rsp_t;

   typedef struct packed
   {
      logic hit;
      logic rd_miss;
      logic wr_miss;
   } stat_event_t;

endpackage

`default_nettype wire

// ==== source/cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

////////////////////////////////////////////////////////////
// cache geometry
////////////////////////////////////////////////////////////
`define CACHE_ADDR_W        30   // byte address, memory-select bits removed
`define CACHE_DATA_W        32
`define CACHE_STRB_W        4
`define CACHE_INDEX_W       10
`define CACHE_WSEL_W        1    // 2**wsel words per line
`define CACHE_TAG_W         17
`define CACHE_WB_DEPTH_LOG2 4

////////////////////////////////////////////////////////////
// statistics port
////////////////////////////////////////////////////////////
`define CACHE_STAT_W        32
`define CACHE_STAT_SEL_W    4
`define CACHE_STAT_HIT      4'd0
`define CACHE_STAT_RD_MISS  4'd1
`define CACHE_STAT_WR_MISS  4'd2
`define CACHE_STAT_INVAL    4'd15
`define CACHE_INVAL_MARKER  32'hDEADBEEF

`endif
